//--- rtl/fe_cfg_pkg.sv
/*
 * Front-end sizes: address and instruction widths,
 * sequential pc step and pc reset value
 */
`default_nettype none

package fe_cfg_pkg;

  // Virtual address and instruction word widths
  localparam int vaddr_width = 32;
  localparam int instr_width = 32;

  // Sequential fetch increment
  localparam logic [vaddr_width-1:0] pc_step = vaddr_width'(4);

  // Pc held after reset until the first command
  localparam logic [vaddr_width-1:0] pc_reset_value = '0;

endpackage

`default_nettype wire

//--- rtl/fe_cmd_decode.sv
/*
 * Command decoder: acknowledge, immediate/complex split
 * and the bypassing resume pc register
 */
`timescale 1ns/1ps
`default_nettype none

module fe_cmd_decode
  (
    input  logic                              clk_i,
    input  logic                              reset_i,

    input  logic                              fe_cmd_v_i,
    input  fe_msg_pkg::fe_cmd_op_e            fe_cmd_op_i,
    input  logic [fe_cfg_pkg::vaddr_width-1:0] fe_cmd_vaddr_i,
    output logic                              fe_cmd_yumi_o,

    input  logic                              running_i,
    input  logic [fe_cfg_pkg::vaddr_width-1:0] if2_pc_i,

    output logic                              cmd_v_o,
    output logic                              cmd_immediate_o,
    output logic                              cmd_complex_o,
    output logic [fe_cfg_pkg::vaddr_width-1:0] resume_pc_o
  );

  import fe_cfg_pkg::*;
  import fe_msg_pkg::*;

  logic                   op_pc_redirect;
  logic                   op_fill_response;
  logic                   immediate_v;
  logic                   resume_en;
  logic [vaddr_width-1:0] resume_n;
  logic [vaddr_width-1:0] resume_r;

  assign op_pc_redirect   = (fe_cmd_op_i == e_op_pc_redirect);
  assign op_fill_response = (fe_cmd_op_i == e_op_icache_fill_response);

  // Every command is consumed in the cycle it shows up
  assign fe_cmd_yumi_o = fe_cmd_v_i;
  assign cmd_v_o       = fe_cmd_v_i;

  // Immediate commands restart fetch right away
  assign immediate_v     = fe_cmd_v_i & (op_pc_redirect | op_fill_response);
  assign cmd_immediate_o = immediate_v;

  // State reset, or anything not recognised, parks the machine in stall
  assign cmd_complex_o = fe_cmd_v_i & ~immediate_v;

  // A command loads its vaddr, otherwise track IF2 while running
  assign resume_en = fe_cmd_v_i | running_i;
  assign resume_n  = fe_cmd_v_i ? fe_cmd_vaddr_i : if2_pc_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resume_r <= pc_reset_value;
    end
    else if (resume_en)
    begin
      resume_r <= resume_n;
    end
  end

  // Bypass so a redirect sees the new vaddr in its own cycle
  assign resume_pc_o = resume_en ? resume_n : resume_r;

endmodule

`default_nettype wire

//--- rtl/fe_fetch_ctrl.sv
/*
 * Fetch control: wait/run/stall FSM, IF1/IF2 valid bits,
 * poison, fetch fail and enqueue decision
 */
`timescale 1ns/1ps
`default_nettype none

module fe_fetch_ctrl
  (
    input  logic clk_i,
    input  logic reset_i,

    input  logic cmd_v_i,
    input  logic cmd_immediate_i,
    input  logic cmd_complex_i,

    input  logic if2_exception_i,
    input  logic instr_v_i,
    input  logic fe_queue_ready_i,

    output logic redirect_o,
    output logic advance_o,
    output logic running_o,
    output logic if2_v_o,
    output logic fe_queue_v_o
  );

  import fe_msg_pkg::*;

  fe_state_e state_r;
  fe_state_e state_n;
  logic      v_if1_r;
  logic      v_if2_r;
  logic      is_stall;
  logic      fe_instr_v;
  logic      queue_miss;
  logic      poison;
  logic      fetch_fail;
  logic      exception_sent;
  logic      unstall;

  assign is_stall  = (state_r == e_stall);
  assign running_o = (state_r == e_run);
  assign if2_v_o   = v_if2_r;

  assign fe_instr_v = v_if2_r & instr_v_i;
  assign queue_miss = v_if2_r & ~fe_queue_ready_i;

  // Nothing goes out in a command cycle
  assign fe_queue_v_o   = fe_queue_ready_i & (fe_instr_v | if2_exception_i) & ~cmd_v_i;
  assign exception_sent = fe_queue_v_o & if2_exception_i;
  assign fetch_fail     = v_if2_r & ~fe_queue_v_o;

  // Younger fetch in IF1 is dropped whenever IF2 does not retire normally
  assign poison  = cmd_v_i | queue_miss | if2_exception_i;
  assign unstall = fe_queue_ready_i & ~cmd_v_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_wait:
      begin
        if (cmd_immediate_i)
          state_n = e_run;
        else if (cmd_complex_i)
          state_n = e_stall;
      end
      e_stall:
      begin
        if (cmd_immediate_i || unstall)
          state_n = e_run;
      end
      e_run:
      begin
        // Immediate command keeps running from the new pc
        if (cmd_immediate_i)
          state_n = e_run;
        else if (fetch_fail || cmd_complex_i)
          state_n = e_stall;
        else if (exception_sent)
          state_n = e_wait;
      end
      default:
        state_n = e_wait;
    endcase
  end

  assign advance_o  = (state_n == e_run);
  assign redirect_o = cmd_immediate_i | (is_stall & advance_o);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_wait;
      v_if1_r <= 1'b0;
      v_if2_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      v_if1_r <= advance_o;
      v_if2_r <= v_if1_r & ~poison & ~fetch_fail;
    end
  end

endmodule

`default_nettype wire

//--- rtl/fe_fetch_stage.sv
/*
 * Fetch stage datapath: IF1 to IF2 pc register, fault and
 * miss detection, queue message assembly
 */
`timescale 1ns/1ps
`default_nettype none

module fe_fetch_stage
  (
    input  logic                                          clk_i,
    input  logic                                          reset_i,

    input  logic [fe_cfg_pkg::vaddr_width-1:0]            if1_pc_i,
    input  logic                                          if2_v_i,

    input  logic                                          instr_v_i,
    input  logic [fe_cfg_pkg::instr_width-1:0]            instr_i,
    input  logic                                          instr_fault_i,

    output logic [fe_cfg_pkg::vaddr_width-1:0]            if2_pc_o,
    output logic                                          if2_exception_o,

    output logic [$bits(fe_msg_pkg::fe_msg_type_e)-1:0]   fe_queue_type_o,
    output logic [fe_cfg_pkg::vaddr_width-1:0]            fe_queue_pc_o,
    output logic [fe_cfg_pkg::instr_width-1:0]            fe_queue_instr_o,
    output logic [$bits(fe_msg_pkg::fe_exc_code_e)-1:0]   fe_queue_exc_o
  );

  import fe_cfg_pkg::*;
  import fe_msg_pkg::*;

  logic [vaddr_width-1:0] if2_pc_r;
  logic                   exception_v;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      if2_pc_r <= pc_reset_value;
    else
      if2_pc_r <= if1_pc_i;
  end

  // Memory answer lines up with IF2, a missing hit counts as a cache miss
  assign exception_v     = if2_v_i & (instr_fault_i | ~instr_v_i);
  assign if2_exception_o = exception_v;
  assign if2_pc_o        = if2_pc_r;

  assign fe_queue_type_o  = exception_v ? e_fe_exception : e_fe_fetch;
  assign fe_queue_pc_o    = if2_pc_r;
  assign fe_queue_instr_o = exception_v ? '0 : instr_i;

  // Access fault wins over cache miss
  assign fe_queue_exc_o = !exception_v  ? '0
                        : instr_fault_i ? e_instr_access_fault
                        :                 e_icache_miss;

endmodule

`default_nettype wire

//--- rtl/fe_msg_pkg.sv
/*
 * Front-end encodings: command opcodes, control states,
 * queue message kinds and fetch exception codes
 */
`default_nettype none

package fe_msg_pkg;

  // Commands from the back end
  typedef enum logic [1:0]
  {
    e_op_state_reset          = 2'd0,
    e_op_pc_redirect          = 2'd1,
    e_op_icache_fill_response = 2'd2
  } fe_cmd_op_e;

  // Control FSM states
  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  // Zero is left free so a fetch message carries no code
  typedef enum logic [1:0]
  {
    e_instr_access_fault = 2'd1,
    e_icache_miss        = 2'd2
  } fe_exc_code_e;

endpackage

`default_nettype wire

//--- rtl/fe_pc_gen.sv
/*
 * Pc generator: next fetch address selection,
 * fetch request and IF1 pc
 */
`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen
  (
    input  logic                               clk_i,
    input  logic                               reset_i,

    input  logic                               redirect_i,
    input  logic [fe_cfg_pkg::vaddr_width-1:0] resume_pc_i,
    input  logic                               advance_i,

    output logic                               fetch_v_o,
    output logic [fe_cfg_pkg::vaddr_width-1:0] fetch_addr_o,
    output logic [fe_cfg_pkg::vaddr_width-1:0] if1_pc_o
  );

  import fe_cfg_pkg::*;

  logic [vaddr_width-1:0] next_pc;
  logic [vaddr_width-1:0] pc_r;

  // Redirect takes the resume pc, otherwise step past the last request
  assign next_pc = redirect_i ? resume_pc_i : (pc_r + pc_step);

  assign fetch_v_o    = advance_i;
  assign fetch_addr_o = next_pc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r <= pc_reset_value;
    end
    else if (advance_i)
    begin
      pc_r <= next_pc;
    end
  end

  // Last issued pc, which sits in IF1 the cycle after issue
  assign if1_pc_o = pc_r;

endmodule

`default_nettype wire

//--- rtl/fe_top.sv
/*
 * Front-end top level: command decoder, pc generator,
 * fetch control and fetch stage
 */
`timescale 1ns/1ps
`default_nettype none

module fe_top
  (
    input  logic                                        clk_i,
    input  logic                                        reset_i,

    input  logic                                        fe_cmd_v_i,
    input  fe_msg_pkg::fe_cmd_op_e                      fe_cmd_op_i,
    input  logic [fe_cfg_pkg::vaddr_width-1:0]          fe_cmd_vaddr_i,
    output logic                                        fe_cmd_yumi_o,

    output logic                                        fetch_v_o,
    output logic [fe_cfg_pkg::vaddr_width-1:0]          fetch_addr_o,
    input  logic                                        instr_v_i,
    input  logic [fe_cfg_pkg::instr_width-1:0]          instr_i,
    input  logic                                        instr_fault_i,

    output logic                                        fe_queue_v_o,
    output logic [$bits(fe_msg_pkg::fe_msg_type_e)-1:0] fe_queue_type_o,
    output logic [fe_cfg_pkg::vaddr_width-1:0]          fe_queue_pc_o,
    output logic [fe_cfg_pkg::instr_width-1:0]          fe_queue_instr_o,
    output logic [$bits(fe_msg_pkg::fe_exc_code_e)-1:0] fe_queue_exc_o,
    input  logic                                        fe_queue_ready_i
  );

  import fe_cfg_pkg::*;

  logic                   cmd_v;
  logic                   cmd_immediate;
  logic                   cmd_complex;
  logic [vaddr_width-1:0] resume_pc;
  logic                   redirect;
  logic                   advance;
  logic                   running;
  logic [vaddr_width-1:0] if1_pc;
  logic [vaddr_width-1:0] if2_pc;
  logic                   if2_v;
  logic                   if2_exception;

  fe_cmd_decode cmd_decode_i
    (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .fe_cmd_v_i      (fe_cmd_v_i),
      .fe_cmd_op_i     (fe_cmd_op_i),
      .fe_cmd_vaddr_i  (fe_cmd_vaddr_i),
      .fe_cmd_yumi_o   (fe_cmd_yumi_o),
      .running_i       (running),
      .if2_pc_i        (if2_pc),
      .cmd_v_o         (cmd_v),
      .cmd_immediate_o (cmd_immediate),
      .cmd_complex_o   (cmd_complex),
      .resume_pc_o     (resume_pc)
    );

  fe_pc_gen pc_gen_i
    (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .redirect_i   (redirect),
      .resume_pc_i  (resume_pc),
      .advance_i    (advance),
      .fetch_v_o    (fetch_v_o),
      .fetch_addr_o (fetch_addr_o),
      .if1_pc_o     (if1_pc)
    );

  fe_fetch_ctrl fetch_ctrl_i
    (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .cmd_v_i          (cmd_v),
      .cmd_immediate_i  (cmd_immediate),
      .cmd_complex_i    (cmd_complex),
      .if2_exception_i  (if2_exception),
      .instr_v_i        (instr_v_i),
      .fe_queue_ready_i (fe_queue_ready_i),
      .redirect_o       (redirect),
      .advance_o        (advance),
      .running_o        (running),
      .if2_v_o          (if2_v),
      .fe_queue_v_o     (fe_queue_v_o)
    );

  fe_fetch_stage fetch_stage_i
    (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .if1_pc_i         (if1_pc),
      .if2_v_i          (if2_v),
      .instr_v_i        (instr_v_i),
      .instr_i          (instr_i),
      .instr_fault_i    (instr_fault_i),
      .if2_pc_o         (if2_pc),
      .if2_exception_o  (if2_exception),
      .fe_queue_type_o  (fe_queue_type_o),
      .fe_queue_pc_o    (fe_queue_pc_o),
      .fe_queue_instr_o (fe_queue_instr_o),
      .fe_queue_exc_o   (fe_queue_exc_o)
    );

endmodule

`default_nettype wire

//--- tb/fe_clk_gen.sv
/*
 * Testbench clock and synchronous reset generator
 */
`timescale 1ns/1ps
`default_nettype none

module fe_clk_gen
  (
    output logic clk_o,
    output logic reset_o
  );

  // 20 ns period
  always #10 clk_o = ~clk_o;

  initial
  begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (10) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb/fe_tb.sv
/*
 * Front-end testbench: two-cycle instruction memory model,
 * directed tests and result report
 */
`timescale 1ns/1ps
`default_nettype none

module fe_tb;

  import fe_cfg_pkg::*;
  import fe_msg_pkg::*;

  logic                            clk;
  logic                            reset;
  logic                            fe_cmd_v;
  fe_cmd_op_e                      fe_cmd_op;
  logic [vaddr_width-1:0]          fe_cmd_vaddr;
  logic                            fe_cmd_yumi;
  logic                            fetch_v;
  logic [vaddr_width-1:0]          fetch_addr;
  logic                            instr_v;
  logic [instr_width-1:0]          instr;
  logic                            instr_fault;
  logic                            fe_queue_v;
  logic [$bits(fe_msg_type_e)-1:0] fe_queue_type;
  logic [vaddr_width-1:0]          fe_queue_pc;
  logic [instr_width-1:0]          fe_queue_instr;
  logic [$bits(fe_exc_code_e)-1:0] fe_queue_exc;
  logic                            fe_queue_ready;

  // Memory delay line and the miss and fault addresses chosen by a test
  logic                   mem_v_q1;
  logic                   mem_v_q2;
  logic [vaddr_width-1:0] mem_addr_q1;
  logic [vaddr_width-1:0] mem_addr_q2;
  logic                   miss_en;
  logic [vaddr_width-1:0] miss_addr;
  logic                   fault_en;
  logic [vaddr_width-1:0] fault_addr;

  int checks;
  int errors;
  int timeouts;

  fe_clk_gen clk_gen_i (.clk_o(clk), .reset_o(reset));

  fe_top dut_i
    (
      .clk_i            (clk),
      .reset_i          (reset),
      .fe_cmd_v_i       (fe_cmd_v),
      .fe_cmd_op_i      (fe_cmd_op),
      .fe_cmd_vaddr_i   (fe_cmd_vaddr),
      .fe_cmd_yumi_o    (fe_cmd_yumi),
      .fetch_v_o        (fetch_v),
      .fetch_addr_o     (fetch_addr),
      .instr_v_i        (instr_v),
      .instr_i          (instr),
      .instr_fault_i    (instr_fault),
      .fe_queue_v_o     (fe_queue_v),
      .fe_queue_type_o  (fe_queue_type),
      .fe_queue_pc_o    (fe_queue_pc),
      .fe_queue_instr_o (fe_queue_instr),
      .fe_queue_exc_o   (fe_queue_exc),
      .fe_queue_ready_i (fe_queue_ready)
    );

  // Answer comes back two cycles after the request
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mem_v_q1    <= 1'b0;
      mem_v_q2    <= 1'b0;
      mem_addr_q1 <= '0;
      mem_addr_q2 <= '0;
    end
    else
    begin
      mem_v_q1    <= fetch_v;
      mem_v_q2    <= mem_v_q1;
      mem_addr_q1 <= fetch_addr;
      mem_addr_q2 <= mem_addr_q1;
    end
  end

  assign instr_v     = mem_v_q2 & ~(miss_en & (mem_addr_q2 == miss_addr));
  assign instr       = instr_width'(~mem_addr_q2);
  assign instr_fault = mem_v_q2 & fault_en & (mem_addr_q2 == fault_addr);

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, field, expected, actual);
    end
  endtask

  task automatic check_true(input string test_name, input logic cond, input string what);
    checks++;
    assert (cond === 1'b1)
    else
    begin
      errors++;
      $display("ERROR %s: %s", test_name, what);
    end
  endtask

  task automatic check_quiet(input string test_name);
    check_value(test_name, "fe_queue_v", 0, fe_queue_v);
    check_value(test_name, "fetch_v", 0, fetch_v);
    check_value(test_name, "fe_cmd_yumi", 0, fe_cmd_yumi);
  endtask

  task automatic check_fetch(input string test_name, input logic [vaddr_width-1:0] pc);
    check_value(test_name, "type", e_fe_fetch, fe_queue_type);
    check_value(test_name, "pc", pc, fe_queue_pc);
    check_value(test_name, "instr", ~pc, fe_queue_instr);
    check_value(test_name, "exc", 0, fe_queue_exc);
  endtask

  task automatic check_exception(input string test_name, input logic [vaddr_width-1:0] pc,
                                 input fe_exc_code_e code);
    check_value(test_name, "type", e_fe_exception, fe_queue_type);
    check_value(test_name, "pc", pc, fe_queue_pc);
    check_value(test_name, "instr", 0, fe_queue_instr);
    check_value(test_name, "exc", code, fe_queue_exc);
  endtask

  task automatic set_memory(input logic miss_on, input logic [vaddr_width-1:0] miss_at,
                            input logic fault_on, input logic [vaddr_width-1:0] fault_at);
    @(posedge clk);
    miss_en    <= miss_on;
    miss_addr  <= miss_at;
    fault_en   <= fault_on;
    fault_addr <= fault_at;
  endtask

  // Returns at the rising edge after the command cycle
  task automatic send_command(input string test_name, input fe_cmd_op_e op,
                              input logic [vaddr_width-1:0] vaddr,
                              output logic issued_v, output logic [vaddr_width-1:0] issued_addr);
    @(posedge clk);
    fe_cmd_v     <= 1'b1;
    fe_cmd_op    <= op;
    fe_cmd_vaddr <= vaddr;
    @(negedge clk);
    check_value(test_name, "fe_cmd_yumi", 1, fe_cmd_yumi);
    check_true(test_name, !fe_queue_v, "queue valid in a command cycle");
    issued_v    = fetch_v;
    issued_addr = fetch_addr;
    @(posedge clk);
    fe_cmd_v <= 1'b0;
  endtask

  task automatic wait_message(input string test_name, input int limit,
                              output int cycles, output logic found);
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
      found = fe_queue_v;
    end
    if (!found)
    begin
      timeouts++;
      $display("ERROR %s: no queue message within %0d cycles", test_name, limit);
    end
  endtask

  task automatic expect_stream(input string test_name, input logic [vaddr_width-1:0] start_pc,
                               input int count, input int first_latency);
    int   cycles;
    logic found;
    for (int i = 0; i < count; i++)
    begin
      wait_message(test_name, 20, cycles, found);
      if (found)
      begin
        check_value(test_name, "latency", (i == 0) ? first_latency : 1, cycles);
        check_fetch(test_name, start_pc + i * pc_step);
      end
    end
  endtask

  task automatic test_reset_quiet();
    int waited;
    waited = 0;
    @(posedge clk);
    while (reset && waited < 20)
    begin
      @(negedge clk);
      check_quiet("reset_quiet");
      waited++;
    end
    if (reset)
    begin
      timeouts++;
      $display("ERROR reset_quiet: reset never deasserted");
    end
    repeat (5)
    begin
      @(negedge clk);
      check_quiet("reset_quiet");
    end
  endtask

  task automatic test_redirect_stream();
    logic                   issued_v;
    logic [vaddr_width-1:0] issued_addr;
    send_command("redirect_stream", e_op_pc_redirect, 32'h1000, issued_v, issued_addr);
    check_value("redirect_stream", "fetch_v", 1, issued_v);
    check_value("redirect_stream", "fetch_addr", 32'h1000, issued_addr);
    expect_stream("redirect_stream", 32'h1000, 10, 2);
  endtask

  task automatic test_back_pressure();
    logic                   issued_v;
    logic [vaddr_width-1:0] issued_addr;
    logic [vaddr_width-1:0] expected;
    int                     accepted;
    int                     cycles;
    logic                   found;
    send_command("back_pressure", e_op_pc_redirect, 32'h2000, issued_v, issued_addr);
    expected = 32'h2000;
    accepted = 0;
    repeat (200)
    begin
      @(posedge clk);
      fe_queue_ready <= 1'($urandom % 2);
      @(negedge clk);
      check_true("back_pressure", !(fe_queue_v && !fe_queue_ready),
                 "queue valid raised while ready was low");
      if (fe_queue_v)
      begin
        check_fetch("back_pressure", expected);
        expected = expected + pc_step;
        accepted++;
      end
    end
    @(posedge clk);
    fe_queue_ready <= 1'b1;
    wait_message("back_pressure", 20, cycles, found);
    if (found)
      check_fetch("back_pressure", expected);
    check_true("back_pressure", accepted >= 10, "too few messages accepted");
  endtask

  task automatic test_miss_fill();
    logic                   issued_v;
    logic [vaddr_width-1:0] issued_addr;
    int                     cycles;
    logic                   found;
    set_memory(1'b1, 32'h3008, 1'b0, '0);
    send_command("miss_fill", e_op_pc_redirect, 32'h3000, issued_v, issued_addr);
    expect_stream("miss_fill", 32'h3000, 2, 2);
    wait_message("miss_fill", 20, cycles, found);
    if (found)
    begin
      check_value("miss_fill", "latency", 1, cycles);
      check_exception("miss_fill", 32'h3008, e_icache_miss);
    end
    // FSM sits in wait until the next command
    repeat (10)
    begin
      @(negedge clk);
      check_quiet("miss_fill");
    end
    set_memory(1'b0, '0, 1'b0, '0);
    send_command("miss_fill", e_op_icache_fill_response, 32'h3008, issued_v, issued_addr);
    check_value("miss_fill", "fetch_v", 1, issued_v);
    check_value("miss_fill", "fetch_addr", 32'h3008, issued_addr);
    expect_stream("miss_fill", 32'h3008, 4, 2);
  endtask

  task automatic test_fault_priority();
    logic                   issued_v;
    logic [vaddr_width-1:0] issued_addr;
    int                     cycles;
    logic                   found;
    set_memory(1'b1, 32'h4004, 1'b1, 32'h4004);
    send_command("fault_priority", e_op_pc_redirect, 32'h4000, issued_v, issued_addr);
    expect_stream("fault_priority", 32'h4000, 1, 2);
    wait_message("fault_priority", 20, cycles, found);
    if (found)
      check_exception("fault_priority", 32'h4004, e_instr_access_fault);
    set_memory(1'b0, '0, 1'b0, '0);
  endtask

  task automatic test_command_flush();
    logic                   issued_v;
    logic [vaddr_width-1:0] issued_addr;
    send_command("command_flush", e_op_pc_redirect, 32'h5000, issued_v, issued_addr);
    expect_stream("command_flush", 32'h5000, 5, 2);
    send_command("command_flush", e_op_state_reset, 32'h6000, issued_v, issued_addr);
    check_value("command_flush", "fetch_v", 0, issued_v);
    expect_stream("command_flush", 32'h6000, 4, 3);
  endtask

  initial
  begin
    void'($urandom(32'h3c5));
    fe_cmd_v       = 1'b0;
    fe_cmd_op      = e_op_state_reset;
    fe_cmd_vaddr   = '0;
    fe_queue_ready = 1'b1;
    miss_en        = 1'b0;
    miss_addr      = '0;
    fault_en       = 1'b0;
    fault_addr     = '0;
    checks         = 0;
    errors         = 0;
    timeouts       = 0;
    test_reset_quiet();
    test_redirect_stream();
    test_back_pressure();
    test_miss_fill();
    test_fault_priority();
    test_command_flush();
    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin
    #100000;
    $display("ERROR watchdog: simulation did not finish in time");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/fe_cfg_pkg.sv
rtl/fe_msg_pkg.sv
rtl/fe_cmd_decode.sv
rtl/fe_pc_gen.sv
rtl/fe_fetch_ctrl.sv
rtl/fe_fetch_stage.sv
rtl/fe_top.sv
tb/fe_clk_gen.sv
tb/fe_tb.sv
